// File: src/video_pkg.sv
package video_pkg;

  // ========================================
  // Pixel format
  // ========================================

  localparam int COLOR_W = 8;

  // Red sits in the upper byte, blue in the lower
  typedef struct packed {
    logic [COLOR_W-1:0] r;
    logic [COLOR_W-1:0] g;
    logic [COLOR_W-1:0] b;
  } rgb_t;

  // Limited range maps 0..255 onto 16..235
  localparam logic [COLOR_W-1:0] LIMIT_COEFF  = 8'd220;
  localparam logic [COLOR_W-1:0] LIMIT_OFFSET = 8'd16;

  // ========================================
  // Output video modes
  // ========================================

  typedef enum logic [4:0] {
    VM_240P60  = 5'd0,
    VM_288P50  = 5'd1,
    VM_480P60  = 5'd2,
    VM_VGAP60  = 5'd3,
    VM_576P50  = 5'd4,
    VM_720P60  = 5'd5,
    VM_720P50  = 5'd6,
    VM_960P60  = 5'd7,
    VM_960P50  = 5'd8,
    VM_1080P60 = 5'd9,
    VM_1080P50 = 5'd10,
    VM_1200P60 = 5'd11,
    VM_1200P50 = 5'd12,
    VM_1440P60 = 5'd13,
    VM_1440P50 = 5'd14
  } vmode_t;

endpackage

// File: src/ppu_cfg_pkg.sv
package ppu_cfg_pkg;

  localparam int PPU_CFG_W = 32;

  // ========================================
  // Target resolution codes
  // ========================================

  typedef enum logic [3:0] {
    T240P  = 4'd0,
    T288P  = 4'd1,
    T480P  = 4'd2,
    T576P  = 4'd3,
    T720P  = 4'd4,
    T960P  = 4'd5,
    T1080P = 4'd6,
    T1200P = 4'd7,
    T1440P = 4'd8
  } target_res_t;

  // ========================================
  // Configuration word layout
  // ========================================

  localparam int TARGET_RES_LSB  = 0;
  localparam int TARGET_RES_W    = 4;

  localparam int USE_VGA_BIT     = 4;
  localparam int FORCE60_BIT     = 5;
  localparam int FORCE50_BIT     = 6;
  localparam int LOW_LATENCY_BIT = 7;
  localparam int LIMITED_RGB_BIT = 8;
  localparam int SL_LINKED_BIT   = 9;

  // Scanline profiles, one byte each
  localparam int SL_PROF_W       = 8;
  localparam int SL240P_LSB      = 16;
  localparam int SL480I_LSB      = 24;

  // Fields inside one profile byte
  localparam int SL_STR_LSB      = 0;
  localparam int SL_STR_IN_W     = 4;
  localparam int SL_THICK_LSB    = 4;
  localparam int SL_THICK_W      = 2;
  localparam int SL_H_EN_BIT     = 6;
  localparam int SL_V_EN_BIT     = 7;

  // Strength after expansion to the multiplier width
  localparam int SL_STR_W        = 8;

endpackage

// File: src/ppu_cfg_decode.sv
`timescale 1ns/100ps

module ppu_cfg_decode (
  input  logic                              VCLK_Tx,
  input  logic                              nVRST_Tx,
  input  logic [ppu_cfg_pkg::PPU_CFG_W-1:0] config_i,
  input  logic                              palmode_i,
  input  logic                              n64_480i_i,
  output video_pkg::vmode_t                 vmode_o,
  output logic                              interlaced_o,
  output logic                              sl_v_en_o,
  output logic                              sl_h_en_o,
  output logic [1:0]                        sl_thickness_o,
  output logic [ppu_cfg_pkg::SL_STR_W-1:0]  sl_strength_o,
  output logic                              limited_rgb_o
);

  import video_pkg::*;
  import ppu_cfg_pkg::*;

  target_res_t            target;
  logic                   low_latency;
  logic                   force60_ok;
  logic                   force50_ok;
  vmode_t                 vmode_60;
  vmode_t                 vmode_50;
  vmode_t                 vmode_nxt;
  logic [SL_PROF_W-1:0]   sl_prof;
  logic [SL_STR_IN_W-1:0] sl_str_raw;
  logic [SL_STR_W-1:0]    sl_str_exp;

  assign target      = target_res_t'(config_i[TARGET_RES_LSB +: TARGET_RES_W]);
  assign low_latency = config_i[LOW_LATENCY_BIT];

  // ========================================
  // Video mode
  // ========================================

  always_comb begin
    case (target)
      T1440P:  vmode_60 = VM_1440P60;
      T1200P:  vmode_60 = VM_1200P60;
      T1080P:  vmode_60 = VM_1080P60;
      T960P:   vmode_60 = VM_960P60;
      T720P:   vmode_60 = VM_720P60;
      T240P:   vmode_60 = VM_240P60;
      default: vmode_60 = config_i[USE_VGA_BIT] ? VM_VGAP60 : VM_480P60;
    endcase
  end

  always_comb begin
    case (target)
      T1440P:  vmode_50 = VM_1440P50;
      T1200P:  vmode_50 = VM_1200P50;
      T1080P:  vmode_50 = VM_1080P50;
      T960P:   vmode_50 = VM_960P50;
      T720P:   vmode_50 = VM_720P50;
      T576P:   vmode_50 = VM_576P50;
      default: vmode_50 = VM_288P50;
    endcase
  end

  // No forcing in low latency mode, nor against a 240p/288p target
  assign force60_ok = config_i[FORCE60_BIT] && !low_latency && (target != T288P);
  assign force50_ok = config_i[FORCE50_BIT] && !low_latency && (target != T240P);

  always_comb begin
    if (force60_ok) begin
      vmode_nxt = vmode_60;
    end else if (force50_ok) begin
      vmode_nxt = vmode_50;
    end else begin
      vmode_nxt = palmode_i ? vmode_50 : vmode_60;
    end
  end

  // ========================================
  // Scanline profile
  // ========================================

  assign sl_prof = (!n64_480i_i || config_i[SL_LINKED_BIT]) ?
                   config_i[SL240P_LSB +: SL_PROF_W] :
                   config_i[SL480I_LSB +: SL_PROF_W];

  assign sl_str_raw = sl_prof[SL_STR_LSB +: SL_STR_IN_W];
  // Appending ones gives (s + 1) * 16 - 1
  assign sl_str_exp = {sl_str_raw, {(SL_STR_W - SL_STR_IN_W){1'b1}}};

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vmode_o        <= VM_480P60;
      interlaced_o   <= 1'b0;
      sl_v_en_o      <= 1'b0;
      sl_h_en_o      <= 1'b0;
      sl_thickness_o <= '0;
      sl_strength_o  <= '0;
      limited_rgb_o  <= 1'b0;
    end else begin
      vmode_o        <= vmode_nxt;
      interlaced_o   <= n64_480i_i;
      sl_v_en_o      <= sl_prof[SL_V_EN_BIT];
      sl_h_en_o      <= sl_prof[SL_H_EN_BIT];
      sl_thickness_o <= sl_prof[SL_THICK_LSB +: SL_THICK_W];
      sl_strength_o  <= sl_str_exp;
      limited_rgb_o  <= config_i[LIMITED_RGB_BIT];
    end
  end

endmodule

// File: src/scanline_emu.sv
`timescale 1ns/100ps

module scanline_emu #(
  parameter int SL_POS_W = 8
) (
  input  logic                             VCLK_Tx,
  input  logic                             nVRST_Tx,
  input  video_pkg::rgb_t                  vdata_i,
  input  logic                             de_i,
  input  logic                             hsync_i,
  input  logic                             vsync_i,
  input  logic                             sl_en_i,
  input  logic [1:0]                       sl_thickness_i,
  input  logic [ppu_cfg_pkg::SL_STR_W-1:0] sl_strength_i,
  input  logic [SL_POS_W-1:0]              sl_rel_pos_i,
  output video_pkg::rgb_t                  vdata_o,
  output logic                             de_o,
  output logic                             hsync_o,
  output logic                             vsync_o
);

  import video_pkg::*;
  import ppu_cfg_pkg::*;

  logic [1:0]          pos_msb;
  logic                in_sl;
  logic [SL_STR_W-1:0] gain;
  rgb_t                dark;

  // floor(ch * k / 2^SL_STR_W)
  function automatic logic [COLOR_W-1:0] scale_ch(input logic [COLOR_W-1:0]  ch,
                                                  input logic [SL_STR_W-1:0] k);
    logic [COLOR_W+SL_STR_W-1:0] prod;
    prod = ch * k;
    return prod[COLOR_W+SL_STR_W-1 -: COLOR_W];
  endfunction

  // Thicker lines cover more of the relative position range
  assign pos_msb = sl_rel_pos_i[SL_POS_W-1 -: 2];
  assign in_sl   = sl_en_i && de_i && (pos_msb >= (2'd3 - sl_thickness_i));

  assign gain   = {SL_STR_W{1'b1}} - sl_strength_i;
  assign dark.r = scale_ch(vdata_i.r, gain);
  assign dark.g = scale_ch(vdata_i.g, gain);
  assign dark.b = scale_ch(vdata_i.b, gain);

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      vdata_o <= '0;
      de_o    <= 1'b0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
    end else begin
      vdata_o <= in_sl ? dark : vdata_i;
      de_o    <= de_i;
      hsync_o <= hsync_i;
      vsync_o <= vsync_i;
    end
  end

endmodule

// File: src/rgb_range_limit.sv
`timescale 1ns/100ps

module rgb_range_limit (
  input  logic            VCLK_Tx,
  input  logic            nVRST_Tx,
  input  video_pkg::rgb_t vdata_i,
  input  logic            de_i,
  input  logic            hsync_i,
  input  logic            vsync_i,
  input  logic            limited_rgb_i,
  output video_pkg::rgb_t vd_o,
  output logic            de_o,
  output logic            hsync_o,
  output logic            vsync_o
);

  import video_pkg::*;

  localparam int NCH = 3;

  logic [NCH-1:0][COLOR_W-1:0] pix_ch;
  logic [2*COLOR_W-1:0]        prod [NCH];
  logic [COLOR_W:0]            lim_s1 [NCH];
  logic [COLOR_W-1:0]          lim_s2 [NCH];
  logic [NCH-1:0][COLOR_W-1:0] lim_ch;
  rgb_t                        full_s1;
  rgb_t                        full_s2;
  // {vsync, hsync, de}
  logic [2:0]                  sync_s1;
  logic [2:0]                  sync_s2;

  // Index 2 is red
  assign pix_ch = vdata_i;

  always_comb begin
    for (int i = 0; i < NCH; i++) begin
      prod[i]   = pix_ch[i] * LIMIT_COEFF;
      lim_ch[i] = lim_s2[i] + LIMIT_OFFSET;
    end
  end

  // ========================================
  // Three-stage pipeline
  // ========================================

  always_ff @(posedge VCLK_Tx or negedge nVRST_Tx) begin
    if (!nVRST_Tx) begin
      for (int i = 0; i < NCH; i++) begin
        lim_s1[i] <= '0;
        lim_s2[i] <= '0;
      end
      full_s1 <= '0;
      full_s2 <= '0;
      sync_s1 <= '0;
      sync_s2 <= '0;
      vd_o    <= '0;
      de_o    <= 1'b0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
    end else begin
      for (int i = 0; i < NCH; i++) begin
        // Top nine bits, the lowest of them decides the rounding
        lim_s1[i] <= prod[i][2*COLOR_W-1 -: COLOR_W+1];
        lim_s2[i] <= lim_s1[i][COLOR_W:1] + COLOR_W'(lim_s1[i][0]);
      end
      full_s1 <= vdata_i;
      full_s2 <= full_s1;
      sync_s1 <= {vsync_i, hsync_i, de_i};
      sync_s2 <= sync_s1;
      vd_o    <= limited_rgb_i ? rgb_t'(lim_ch) : full_s2;
      vsync_o <= sync_s2[2];
      hsync_o <= sync_s2[1];
      de_o    <= sync_s2[0];
    end
  end

endmodule

// File: src/ppu_video_out.sv
`timescale 1ns/100ps

module ppu_video_out #(
  parameter int SL_POS_W = 8
) (
  input  logic                              VCLK_Tx,
  input  logic                              nVRST_Tx,
  input  logic [ppu_cfg_pkg::PPU_CFG_W-1:0] config_i,
  input  logic                              palmode_i,
  input  logic                              n64_480i_i,
  input  video_pkg::rgb_t                   vdata_i,
  input  logic                              de_i,
  input  logic                              hsync_i,
  input  logic                              vsync_i,
  input  logic [SL_POS_W-1:0]               vpos_rel_i,
  input  logic [SL_POS_W-1:0]               hpos_rel_i,
  output video_pkg::rgb_t                   vd_o,
  output logic                              de_o,
  output logic                              hsync_o,
  output logic                              vsync_o,
  output video_pkg::vmode_t                 vmode_o,
  output logic                              interlaced_o
);

  import video_pkg::*;
  import ppu_cfg_pkg::*;

  logic                sl_v_en;
  logic                sl_h_en;
  logic [1:0]          sl_thickness;
  logic [SL_STR_W-1:0] sl_strength;
  logic                limited_rgb;

  rgb_t                hsl_vdata;
  logic                hsl_de;
  logic                hsl_hsync;
  logic                hsl_vsync;

  rgb_t                vsl_vdata;
  logic                vsl_de;
  logic                vsl_hsync;
  logic                vsl_vsync;

  ppu_cfg_decode cfg_decode_u (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .config_i       (config_i),
    .palmode_i      (palmode_i),
    .n64_480i_i     (n64_480i_i),
    .vmode_o        (vmode_o),
    .interlaced_o   (interlaced_o),
    .sl_v_en_o      (sl_v_en),
    .sl_h_en_o      (sl_h_en),
    .sl_thickness_o (sl_thickness),
    .sl_strength_o  (sl_strength),
    .limited_rgb_o  (limited_rgb)
  );

  // ========================================
  // Scanlines, horizontal then vertical
  // ========================================

  // Horizontal lines are keyed by the vertical position
  scanline_emu #(
    .SL_POS_W (SL_POS_W)
  ) hor_scanline_u (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .vdata_i        (vdata_i),
    .de_i           (de_i),
    .hsync_i        (hsync_i),
    .vsync_i        (vsync_i),
    .sl_en_i        (sl_h_en),
    .sl_thickness_i (sl_thickness),
    .sl_strength_i  (sl_strength),
    .sl_rel_pos_i   (vpos_rel_i),
    .vdata_o        (hsl_vdata),
    .de_o           (hsl_de),
    .hsync_o        (hsl_hsync),
    .vsync_o        (hsl_vsync)
  );

  scanline_emu #(
    .SL_POS_W (SL_POS_W)
  ) vert_scanline_u (
    .VCLK_Tx        (VCLK_Tx),
    .nVRST_Tx       (nVRST_Tx),
    .vdata_i        (hsl_vdata),
    .de_i           (hsl_de),
    .hsync_i        (hsl_hsync),
    .vsync_i        (hsl_vsync),
    .sl_en_i        (sl_v_en),
    .sl_thickness_i (sl_thickness),
    .sl_strength_i  (sl_strength),
    .sl_rel_pos_i   (hpos_rel_i),
    .vdata_o        (vsl_vdata),
    .de_o           (vsl_de),
    .hsync_o        (vsl_hsync),
    .vsync_o        (vsl_vsync)
  );

  rgb_range_limit range_limit_u (
    .VCLK_Tx       (VCLK_Tx),
    .nVRST_Tx      (nVRST_Tx),
    .vdata_i       (vsl_vdata),
    .de_i          (vsl_de),
    .hsync_i       (vsl_hsync),
    .vsync_i       (vsl_vsync),
    .limited_rgb_i (limited_rgb),
    .vd_o          (vd_o),
    .de_o          (de_o),
    .hsync_o       (hsync_o),
    .vsync_o       (vsync_o)
  );

endmodule

// File: tests/tb_ppu_video_out.sv
`timescale 1ns/100ps

module tb_ppu_video_out;

  import video_pkg::*;
  import ppu_cfg_pkg::*;

  localparam int SL_POS_W = 8;

  // Test lengths in cycles
  localparam int N_RESET    = 3;
  localparam int N_IDLE     = 4;
  localparam int N_SWEEP    = 9 * 2 * 16;
  localparam int N_PASS     = 200;
  localparam int N_LIMIT    = 200;
  localparam int N_SL_SEG   = 16;
  localparam int N_SL_SEGS  = 10;
  localparam int N_SL       = 4 * N_SL_SEGS * N_SL_SEG;
  localparam int N_DRAIN    = 8;
  localparam int MAX_CYCLES = N_RESET + N_IDLE + N_SWEEP + N_PASS + N_LIMIT + N_SL +
                              N_DRAIN + 50;

  // Everything driven in one cycle
  typedef struct packed {
    logic                 rst_n;
    logic [PPU_CFG_W-1:0] cfg;
    logic                 pal;
    logic                 n64;
    rgb_t                 pix;
    logic                 de;
    logic                 hs;
    logic                 vs;
    logic [SL_POS_W-1:0]  vpos;
    logic [SL_POS_W-1:0]  hpos;
  } stim_t;

  typedef struct packed {
    logic       v_en;
    logic       h_en;
    logic [1:0] thick;
    logic [7:0] str;
  } sl_set_t;

  logic                 VCLK_Tx = 1'b0;
  logic                 nVRST_Tx;
  logic [PPU_CFG_W-1:0] config_i;
  logic                 palmode_i;
  logic                 n64_480i_i;
  rgb_t                 vdata_i;
  logic                 de_i;
  logic                 hsync_i;
  logic                 vsync_i;
  logic [SL_POS_W-1:0]  vpos_rel_i;
  logic [SL_POS_W-1:0]  hpos_rel_i;
  rgb_t                 vd_o;
  logic                 de_o;
  logic                 hsync_o;
  logic                 vsync_o;
  vmode_t               vmode_o;
  logic                 interlaced_o;

  logic [31:0] lfsr = 32'h32d24748;
  stim_t       stim_q[$];
  int          cycle_count = 0;

  ppu_video_out #(
    .SL_POS_W (SL_POS_W)
  ) ppu_video_out_i (
    .VCLK_Tx      (VCLK_Tx),
    .nVRST_Tx     (nVRST_Tx),
    .config_i     (config_i),
    .palmode_i    (palmode_i),
    .n64_480i_i   (n64_480i_i),
    .vdata_i      (vdata_i),
    .de_i         (de_i),
    .hsync_i      (hsync_i),
    .vsync_i      (vsync_i),
    .vpos_rel_i   (vpos_rel_i),
    .hpos_rel_i   (hpos_rel_i),
    .vd_o         (vd_o),
    .de_o         (de_o),
    .hsync_o      (hsync_o),
    .vsync_o      (vsync_o),
    .vmode_o      (vmode_o),
    .interlaced_o (interlaced_o)
  );

  initial begin
    forever #5 VCLK_Tx = ~VCLK_Tx;
  end

  // ========================================
  // Random source
  // ========================================

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_bit()};
    end
    return v;
  endfunction

  // ========================================
  // Reference model
  // ========================================

  function automatic vmode_t mode_60(input logic [3:0] t, input logic use_vga);
    case (t)
      T1440P:  return VM_1440P60;
      T1200P:  return VM_1200P60;
      T1080P:  return VM_1080P60;
      T960P:   return VM_960P60;
      T720P:   return VM_720P60;
      T240P:   return VM_240P60;
      default: return use_vga ? VM_VGAP60 : VM_480P60;
    endcase
  endfunction

  function automatic vmode_t mode_50(input logic [3:0] t);
    case (t)
      T1440P:  return VM_1440P50;
      T1200P:  return VM_1200P50;
      T1080P:  return VM_1080P50;
      T960P:   return VM_960P50;
      T720P:   return VM_720P50;
      T576P:   return VM_576P50;
      default: return VM_288P50;
    endcase
  endfunction

  function automatic vmode_t ref_vmode(input stim_t s);
    logic [3:0] t;
    logic       low_lat;
    logic       use_vga;
    t       = s.cfg[TARGET_RES_LSB +: TARGET_RES_W];
    low_lat = s.cfg[LOW_LATENCY_BIT];
    use_vga = s.cfg[USE_VGA_BIT];
    if (!s.rst_n) begin
      return VM_480P60;
    end
    if (s.cfg[FORCE60_BIT] && !low_lat && (t != T288P)) begin
      return mode_60(t, use_vga);
    end
    if (s.cfg[FORCE50_BIT] && !low_lat && (t != T240P)) begin
      return mode_50(t);
    end
    return s.pal ? mode_50(t) : mode_60(t, use_vga);
  endfunction

  function automatic sl_set_t ref_profile(input stim_t s);
    logic [SL_PROF_W-1:0] prof;
    sl_set_t              r;
    if (!s.n64 || s.cfg[SL_LINKED_BIT]) begin
      prof = s.cfg[SL240P_LSB +: SL_PROF_W];
    end else begin
      prof = s.cfg[SL480I_LSB +: SL_PROF_W];
    end
    r.v_en  = prof[SL_V_EN_BIT];
    r.h_en  = prof[SL_H_EN_BIT];
    r.thick = prof[SL_THICK_LSB +: SL_THICK_W];
    r.str   = 8'((int'(prof[SL_STR_LSB +: SL_STR_IN_W]) + 1) * 16 - 1);
    return r;
  endfunction

  function automatic rgb_t darken(input rgb_t p, input logic en, input logic de,
                                  input logic [1:0] thick, input logic [7:0] str,
                                  input logic [SL_POS_W-1:0] pos);
    int   top;
    int   gain;
    rgb_t r;
    top  = int'(pos[SL_POS_W-1 -: 2]);
    gain = 255 - int'(str);
    r    = p;
    if (en && de && (top >= 3 - int'(thick))) begin
      r.r = 8'(int'(p.r) * gain / 256);
      r.g = 8'(int'(p.g) * gain / 256);
      r.b = 8'(int'(p.b) * gain / 256);
    end
    return r;
  endfunction

  function automatic logic [7:0] limit_ch(input logic [7:0] c);
    return 8'((int'(c) * 220 + 128) / 256 + 16);
  endfunction

  // Each stage sees the settings and position of its own input cycle
  function automatic rgb_t ref_pixel(input stim_t px, input stim_t h_cfg,
                                     input stim_t v_pos, input stim_t lim);
    sl_set_t hor_set;
    sl_set_t ver_set;
    rgb_t    p;
    hor_set = ref_profile(h_cfg);
    ver_set = ref_profile(px);
    p = darken(px.pix, hor_set.h_en, px.de, hor_set.thick, hor_set.str, px.vpos);
    p = darken(p, ver_set.v_en, px.de, ver_set.thick, ver_set.str, v_pos.hpos);
    if (lim.cfg[LIMITED_RGB_BIT]) begin
      p.r = limit_ch(p.r);
      p.g = limit_ch(p.g);
      p.b = limit_ch(p.b);
    end
    return p;
  endfunction

  // ========================================
  // Checking
  // ========================================

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "stopped at first error");
    end
  endtask

  // Last queue entry is the current cycle, so entry b-k is k cycles back
  always @(negedge VCLK_Tx) begin
    int    b;
    logic  flushed;
    stim_t px;
    stim_t dec;
    rgb_t  exp_pix;
    if (cycle_count > 0) begin
      b       = stim_q.size() - 1;
      px      = stim_q[b-5];
      dec     = stim_q[b-1];
      exp_pix = ref_pixel(px, stim_q[b-6], stim_q[b-4], stim_q[b-2]);
      // A reset in any of the last five cycles leaves the video pipeline cleared
      flushed = 1'b0;
      for (int k = 1; k <= 5; k++) begin
        if (!stim_q[b-k].rst_n) begin
          flushed = 1'b1;
        end
      end
      if (flushed) begin
        px      = '0;
        exp_pix = '0;
      end
      check_equal(32'(vd_o), 32'(exp_pix), "vd_o");
      check_equal(32'(de_o), 32'(px.de), "de_o");
      check_equal(32'(hsync_o), 32'(px.hs), "hsync_o");
      check_equal(32'(vsync_o), 32'(px.vs), "vsync_o");
      check_equal(32'(vmode_o), 32'(ref_vmode(dec)), "vmode_o");
      check_equal(32'(interlaced_o), 32'(dec.rst_n & dec.n64), "interlaced_o");
      while (stim_q.size() > 8) begin
        void'(stim_q.pop_front());
      end
    end
  end

  initial begin
    while (cycle_count < MAX_CYCLES) begin
      @(posedge VCLK_Tx);
      cycle_count++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("SIMULATION FAILED");
    $fatal(1, "timeout");
  end

  // ========================================
  // Stimulus
  // ========================================

  task automatic drive_cycle(input stim_t s);
    nVRST_Tx   = s.rst_n;
    config_i   = s.cfg;
    palmode_i  = s.pal;
    n64_480i_i = s.n64;
    vdata_i    = s.pix;
    de_i       = s.de;
    hsync_i    = s.hs;
    vsync_i    = s.vs;
    vpos_rel_i = s.vpos;
    hpos_rel_i = s.hpos;
    stim_q.push_back(s);
    @(posedge VCLK_Tx);
    #1;
  endtask

  function automatic stim_t with_random_video(input stim_t s);
    stim_t r;
    r      = s;
    r.pix  = rgb_t'(24'(rand_bits(24)));
    r.de   = |rand_bits(2);
    r.hs   = 1'(rand_bits(1));
    r.vs   = 1'(rand_bits(1));
    r.vpos = SL_POS_W'(rand_bits(SL_POS_W));
    r.hpos = SL_POS_W'(rand_bits(SL_POS_W));
    return r;
  endfunction

  function automatic stim_t active_rec(input logic [PPU_CFG_W-1:0] cfg);
    stim_t r;
    r       = '0;
    r.rst_n = 1'b1;
    r.cfg   = cfg;
    return r;
  endfunction

  // Phase 0 horizontal only, 1 vertical only, 2 both, 3 as drawn
  function automatic logic [7:0] force_enables(input logic [7:0] prof, input int phase);
    logic [7:0] r;
    r = prof;
    if (phase == 0) begin
      r[SL_H_EN_BIT] = 1'b1;
      r[SL_V_EN_BIT] = 1'b0;
    end else if (phase == 1) begin
      r[SL_H_EN_BIT] = 1'b0;
      r[SL_V_EN_BIT] = 1'b1;
    end else if (phase == 2) begin
      r[SL_H_EN_BIT] = 1'b1;
      r[SL_V_EN_BIT] = 1'b1;
    end
    return r;
  endfunction

  task automatic run_mode_sweep();
    stim_t s;
    s = active_rec('0);
    for (int t = 0; t <= 8; t++) begin
      for (int p = 0; p < 2; p++) begin
        for (int f = 0; f < 16; f++) begin
          s.cfg = '0;
          s.cfg[TARGET_RES_LSB +: TARGET_RES_W] = 4'(t);
          s.cfg[USE_VGA_BIT]     = f[0];
          s.cfg[FORCE60_BIT]     = f[1];
          s.cfg[FORCE50_BIT]     = f[2];
          s.cfg[LOW_LATENCY_BIT] = f[3];
          s.pal = p[0];
          drive_cycle(with_random_video(s));
        end
      end
    end
  endtask

  task automatic run_scanlines(input int phase);
    stim_t      s;
    logic [7:0] p240;
    logic [7:0] p480;
    s = active_rec('0);
    for (int seg = 0; seg < N_SL_SEGS; seg++) begin
      p240 = force_enables(8'(rand_bits(8)), phase);
      p480 = force_enables(8'(rand_bits(8)), phase);
      s.cfg = '0;
      s.cfg[TARGET_RES_LSB +: TARGET_RES_W] = 4'(rand_bits(4));
      s.cfg[LIMITED_RGB_BIT] = 1'(rand_bits(1));
      s.cfg[SL_LINKED_BIT]   = 1'(rand_bits(1));
      s.cfg[SL240P_LSB +: SL_PROF_W] = p240;
      s.cfg[SL480I_LSB +: SL_PROF_W] = p480;
      s.n64 = 1'(rand_bits(1));
      s.pal = 1'(rand_bits(1));
      for (int i = 0; i < N_SL_SEG; i++) begin
        drive_cycle(with_random_video(s));
      end
    end
  endtask

  initial begin
    stim_t                s;
    logic [PPU_CFG_W-1:0] cfg;
    // Older history reads as idle reset cycles
    s = '0;
    for (int i = 0; i < 7; i++) begin
      stim_q.push_back(s);
    end
    // Live video during reset must not reach the outputs
    repeat (N_RESET) drive_cycle(with_random_video(s));

    $display("Reset state and idle");
    repeat (N_IDLE) drive_cycle(active_rec('0));

    $display("Mode table and forcing");
    run_mode_sweep();

    $display("Pass-through");
    cfg = '0;
    cfg[TARGET_RES_LSB +: TARGET_RES_W] = T480P;
    s = active_rec(cfg);
    for (int i = 0; i < N_PASS; i++) begin
      s.n64 = 1'(rand_bits(1));
      drive_cycle(with_random_video(s));
    end

    $display("Limited range");
    cfg[LIMITED_RGB_BIT] = 1'b1;
    s = active_rec(cfg);
    s.de  = 1'b1;
    s.pix = rgb_t'(24'h000000);
    drive_cycle(s);
    s.pix = rgb_t'(24'hffffff);
    drive_cycle(s);
    for (int i = 2; i < N_LIMIT; i++) begin
      drive_cycle(with_random_video(s));
    end

    $display("Scanlines");
    for (int phase = 0; phase < 4; phase++) begin
      run_scanlines(phase);
    end

    repeat (N_DRAIN) drive_cycle(active_rec('0));

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: verilog.f
src/video_pkg.sv
src/ppu_cfg_pkg.sv
src/ppu_cfg_decode.sv
src/scanline_emu.sv
src/rgb_range_limit.sv
src/ppu_video_out.sv
tests/tb_ppu_video_out.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f \
  --top-module tb_ppu_video_out -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
  echo "Testbench reported a failure, see sim.log"
  exit 1
fi
echo "Run finished without failures"
